//--- logic/ps2_pkg.sv
package ps2_pkg;

    // one byte off the keyboard
    typedef logic [7:0] scan_code_t;

    // release prefix
    localparam scan_code_t BREAK_CODE = 8'hF0;

    // start, 8 data, parity, stop
    localparam int FRAME_BITS = 11;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    // pointer carries one wrap bit above the address
    typedef logic [FIFO_AW:0] fifo_ptr_t;

endpackage

//--- logic/display_pkg.sv
package display_pkg;

    localparam int N_DIGITS = 3;

    localparam int DIG_LO  = 0;     // code low nibble
    localparam int DIG_HI  = 1;     // code high nibble
    localparam int DIG_CNT = 2;     // press count

    typedef logic [3:0] nibble_t;

    // active low, bit 0 = a .. bit 6 = g, bit 7 = dp
    typedef logic [7:0] seg_t;

    localparam seg_t SEG_BLANK = 8'hFF;

endpackage

//--- logic/ps2_rx.sv
`timescale 1ns/1ps

module ps2_rx
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    input  logic       nextdata_n,
    output scan_code_t data,
    output logic       ready,
    output logic       overflow
);

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       fall;
    logic [3:0] bit_cnt;
    logic [9:0] frame;
    logic [9:0] idle_cnt;
    logic       frame_done;
    logic       frame_ok;
    logic       full;
    logic       pop;
    fifo_ptr_t  wptr;
    fifo_ptr_t  rptr;
    scan_code_t mem [FIFO_DEPTH];

    // both lines idle high on the bus
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
            fall     <= 1'b0;
        end
        else
        begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
            fall     <= clk_prev & ~clk_sync[1];    // registered edge
        end
    end

    assign frame_done = fall && (bit_cnt == 4'(FRAME_BITS - 1));

    // start low, odd parity over data and parity, stop high
    assign frame_ok = frame_done && !frame[0] && (^frame[9:1]) && dat_sync[1];

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt  <= '0;
            idle_cnt <= '0;
        end
        else if (fall)
        begin
            idle_cnt <= '0;
            if (frame_done)
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 4'd1;
        end
        else if (bit_cnt != '0)
        begin
            idle_cnt <= idle_cnt + 10'd1;
            if (&idle_cnt)
                bit_cnt <= '0;      // keyboard went quiet mid frame
        end
    end

    // start, data and parity; stop is checked on the fly
    always_ff @(posedge clk)
    begin
        if (fall && !frame_done)
            frame[bit_cnt] <= dat_sync[1];
    end

    assign full = (wptr[FIFO_AW] != rptr[FIFO_AW]) &&
                  (wptr[FIFO_AW-1:0] == rptr[FIFO_AW-1:0]);
    assign ready = (wptr != rptr);
    assign pop   = !nextdata_n && ready;
    assign data  = mem[rptr[FIFO_AW-1:0]];

    always_ff @(posedge clk)
    begin
        if (frame_ok && !full)
            mem[wptr[FIFO_AW-1:0]] <= frame[8:1];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wptr     <= '0;
            rptr     <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (frame_ok && !full)
                wptr <= wptr + fifo_ptr_t'(1);
            if (pop)
            begin
                rptr     <= rptr + fifo_ptr_t'(1);
                overflow <= 1'b0;
            end
            if (frame_ok && full)
                overflow <= 1'b1;   // byte lost
        end
    end

endmodule

//--- logic/key_tracker.sv
`timescale 1ns/1ps

module key_tracker
    import ps2_pkg::*, display_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ready,
    input  logic                   overflow,
    input  scan_code_t             data,
    output logic                   nextdata_n,
    output nibble_t [N_DIGITS-1:0] digit_val,
    output logic [N_DIGITS-1:0]    digit_blank
);

    typedef enum logic [2:0]
    {
        idle,
        fetch,
        make_ack,
        break_wait,
        break_fetch,
        break_ack
    } tracker_state_t;

    tracker_state_t state;
    scan_code_t     key_value;
    nibble_t        press_cnt;
    logic           code_blank;
    logic           can_read;

    assign can_read = ready && !overflow;

    always_ff @(posedge clk)
    begin
        if (!rst)
            state <= idle;
        else
        begin
            case (state)
                idle:
                    if (can_read)
                        state <= fetch;
                fetch:
                    if (data == BREAK_CODE)
                        state <= break_wait;
                    else
                        state <= make_ack;
                make_ack:
                    state <= idle;
                // hold until the F0 pop has landed and the next byte is in
                break_wait:
                    if (nextdata_n && can_read)
                        state <= break_fetch;
                break_fetch:
                    state <= break_ack;
                break_ack:
                    state <= idle;
                default:
                    state <= idle;
            endcase
        end
    end

    // one clock low pulse, pops at the end of the ack state
    always_ff @(posedge clk)
    begin
        if (!rst)
            nextdata_n <= 1'b1;
        else
            nextdata_n <= !(state == fetch || state == break_fetch);
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            key_value  <= '0;
            press_cnt  <= '0;
            code_blank <= 1'b1;
        end
        else if (state == fetch && data != BREAK_CODE)
        begin
            key_value  <= data;
            press_cnt  <= press_cnt + 4'd1;     // wraps mod 16
            code_blank <= 1'b0;
        end
        else if (state == break_fetch)
            code_blank <= 1'b1;     // released code is dropped
    end

    always_comb
    begin
        digit_val              = '0;
        digit_val[DIG_LO]      = key_value[3:0];
        digit_val[DIG_HI]      = key_value[7:4];
        digit_val[DIG_CNT]     = press_cnt;
        digit_blank            = '0;
        digit_blank[DIG_LO]    = code_blank;
        digit_blank[DIG_HI]    = code_blank;
    end

endmodule

//--- logic/seg7.sv
`timescale 1ns/1ps

module seg7
    import display_pkg::*;
(
    input  nibble_t num,
    input  logic    clear,
    output seg_t    seg_out
);

    always_comb
    begin
        if (clear)
            seg_out = SEG_BLANK;
        else
        begin
            case (num)
                4'h0: seg_out = 8'hC0;
                4'h1: seg_out = 8'hF9;
                4'h2: seg_out = 8'hA4;
                4'h3: seg_out = 8'hB0;
                4'h4: seg_out = 8'h99;
                4'h5: seg_out = 8'h92;
                4'h6: seg_out = 8'h82;
                4'h7: seg_out = 8'hF8;
                4'h8: seg_out = 8'h80;
                4'h9: seg_out = 8'h90;
                4'hA: seg_out = 8'h88;
                4'hB: seg_out = 8'h83;     // lower case b
                4'hC: seg_out = 8'hC6;
                4'hD: seg_out = 8'hA1;     // lower case d
                4'hE: seg_out = 8'h86;
                4'hF: seg_out = 8'h8E;
                default: seg_out = SEG_BLANK;
            endcase
        end
    end

endmodule

//--- logic/keypad_display.sv
`timescale 1ns/1ps

module keypad_display
    import ps2_pkg::*, display_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    output seg_t [N_DIGITS-1:0] seg
);

    scan_code_t             data;
    logic                   ready;
    logic                   overflow;
    logic                   nextdata_n;
    nibble_t [N_DIGITS-1:0] digit_val;
    logic [N_DIGITS-1:0]    digit_blank;

    ps2_rx u_rx
    (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .nextdata_n (nextdata_n),
        .data       (data),
        .ready      (ready),
        .overflow   (overflow)
    );

    key_tracker u_tracker
    (
        .clk         (clk),
        .rst         (rst),
        .ready       (ready),
        .overflow    (overflow),
        .data        (data),
        .nextdata_n  (nextdata_n),
        .digit_val   (digit_val),
        .digit_blank (digit_blank)
    );

    // digit 0 low nibble, 1 high nibble, 2 press count
    for (genvar i = 0; i < N_DIGITS; i++)
    begin : g_digit
        seg7 u_seg
        (
            .num     (digit_val[i]),
            .clear   (digit_blank[i]),
            .seg_out (seg[i])
        );
    end

endmodule

//--- bench/keypad_display_props.sv
`timescale 1ns/1ps

module keypad_display_props
    import ps2_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       ready,
    input logic       overflow,
    input scan_code_t data,
    input logic       nextdata_n
);

    logic armed;    // readable fifo seen since the last pop
    int   fail_cnt = 0;

    always_ff @(posedge clk)
    begin
        if (!rst)
            armed <= 1'b0;
        else if (!nextdata_n)
            armed <= 1'b0;
        else if (ready && !overflow)
            armed <= 1'b1;
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |=> nextdata_n)
        else
        begin
            fail_cnt++;
            $error("pop pulse longer than one cycle");
        end

    a_pop_ready: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |-> ready)
        else
        begin
            fail_cnt++;
            $error("pop while fifo empty");
        end

    a_pop_rearmed: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |-> armed)
        else
        begin
            fail_cnt++;
            $error("pop without ready seen again");
        end

    a_data_known: assert property (@(posedge clk) disable iff (!rst)
        !nextdata_n |-> !$isunknown(data))
        else
        begin
            fail_cnt++;
            $error("fifo head unknown at pop");
        end

endmodule

bind key_tracker keypad_display_props u_props
(
    .clk        (clk),
    .rst        (rst),
    .ready      (ready),
    .overflow   (overflow),
    .data       (data),
    .nextdata_n (nextdata_n)
);

//--- bench/tb_keypad_display.sv
`timescale 1ns/1ps

module tb_keypad_display
    import ps2_pkg::*, display_pkg::*;
();

    localparam int PS2_HALF       = 10;     // system cycles per PS/2 half period
    localparam int SETTLE_CYCLES  = 40;
    localparam int MAX_FRAMES     = 130;
    localparam int TIMEOUT_CYCLES = MAX_FRAMES * 1000 + 2000;

    logic                clk;
    logic                rst;
    logic                ps2_clk;
    logic                ps2_dat;
    seg_t [N_DIGITS-1:0] seg;

    logic [31:0] rng;
    scan_code_t  exp_key;
    logic        exp_blank;
    nibble_t     exp_cnt;
    logic        break_pending;
    int          errors;
    int          checks;
    int          test_no;
    int          test_err;

    keypad_display uut
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg     (seg)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // active low a..g with dp off
    function automatic seg_t seg_pattern(nibble_t n);
        case (n)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    function automatic seg_t expected_seg(nibble_t n, logic blank);
        return blank ? SEG_BLANK : seg_pattern(n);
    endfunction

    function automatic nibble_t seg_to_nibble(seg_t s);
        nibble_t r;
        r = 'x;     // no match stays unknown
        for (int i = 0; i < 16; i++)
            if (seg_pattern(4'(i)) == s)
                r = 4'(i);
        return r;
    endfunction

    task automatic check_seg(string name, seg_t got, seg_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_nibble(string name, nibble_t got, nibble_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_all();
        check_seg("seg[0]", seg[DIG_LO], expected_seg(exp_key[3:0], exp_blank));
        check_seg("seg[1]", seg[DIG_HI], expected_seg(exp_key[7:4], exp_blank));
        check_seg("seg[2]", seg[DIG_CNT], expected_seg(exp_cnt, 1'b0));
        check_nibble("press_count", seg_to_nibble(seg[DIG_CNT]), exp_cnt);
    endtask

    // a good byte as the tracker is expected to see it
    task automatic model_byte(scan_code_t b);
        if (break_pending)
        begin
            exp_blank     = 1'b1;
            break_pending = 1'b0;
        end
        else if (b == BREAK_CODE)
            break_pending = 1'b1;
        else
        begin
            exp_key   = b;
            exp_blank = 1'b0;
            exp_cnt   = exp_cnt + 4'd1;
        end
    endtask

    // corrupt 0 none, 1 parity, 2 start, 3 stop
    task automatic send_frame(scan_code_t code, logic [1:0] corrupt);
        logic [10:0] bits;
        bits = {1'b1, ~^code, code, 1'b0};
        if (corrupt == 2'd1)
            bits[9] = ~bits[9];
        else if (corrupt == 2'd2)
            bits[0] = 1'b1;
        else if (corrupt == 2'd3)
            bits[10] = 1'b0;
        for (int i = 0; i < 11; i++)
        begin
            ps2_dat = bits[i];
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
    endtask

    task automatic frame_and_check(scan_code_t code, logic [1:0] corrupt);
        send_frame(code, corrupt);
        repeat (SETTLE_CYCLES) @(negedge clk);
        if (corrupt == 2'd0)
            model_byte(code);
        check_all();
    endtask

    task automatic start_test();
        test_no++;
        test_err = errors;
    endtask

    task automatic end_test(string name);
        $display("test %0d %s: %0d errors", test_no, name, errors - test_err);
    endtask

    function automatic scan_code_t make_code(logic [31:0] r);
        if (r[7:0] == BREAK_CODE)
            return 8'h1C;
        return r[7:0];
    endfunction

    // watchdog
    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        rst           = 1'b0;
        ps2_clk       = 1'b1;
        ps2_dat       = 1'b1;
        rng           = 32'h89cf;
        exp_key       = '0;
        exp_blank     = 1'b1;
        exp_cnt       = '0;
        break_pending = 1'b0;
        errors        = 0;
        checks        = 0;
        test_no       = 0;
        test_err      = 0;
        repeat (5) @(negedge clk);
        rst = 1'b1;

        start_test();
        repeat (3) @(negedge clk);
        check_all();
        end_test("reset");

        start_test();
        rng = xorshift(rng);
        frame_and_check(make_code(rng), 2'd0);
        end_test("make_code");

        start_test();
        rng = xorshift(rng);
        frame_and_check(BREAK_CODE, 2'd0);
        frame_and_check(exp_key, 2'd0);
        rng = xorshift(rng);
        frame_and_check(make_code(rng), 2'd0);
        end_test("break_then_make");

        start_test();
        for (int k = 1; k <= 3; k++)
        begin
            rng = xorshift(rng);
            frame_and_check(make_code(rng), 2'(k));
        end
        end_test("bad_frames");

        start_test();
        for (int n = 0; n < 60; n++)
        begin
            rng = xorshift(rng);
            case (rng[9:8])
                2'd0, 2'd1:
                    frame_and_check(make_code(rng), 2'd0);
                2'd2:
                begin
                    frame_and_check(BREAK_CODE, 2'd0);
                    frame_and_check(make_code(xorshift(rng)), 2'd0);
                end
                default:
                    frame_and_check(make_code(rng), 2'(1 + rng[17:16] % 3));
            endcase
        end
        end_test("random_run");

        if (uut.u_tracker.u_props.fail_cnt != 0)
            $display("%0d protocol assertions failed", uut.u_tracker.u_props.fail_cnt);
        errors = errors + uut.u_tracker.u_props.fail_cnt;

        $display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- tb.f
logic/ps2_pkg.sv
logic/display_pkg.sv
logic/ps2_rx.sv
logic/key_tracker.sv
logic/seg7.sv
logic/keypad_display.sv
bench/keypad_display_props.sv
bench/tb_keypad_display.sv
